// ==== logic/dcache_pkg.sv ====
//########################################
// Data cache write port definitions
// Widths and types of address, data and
// byte mask seen by the cache
//########################################

package dcache_pkg;

    // One cache word
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    // One mask bit per data byte
    localparam int unsigned MASK_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [MASK_W-1:0] mask_t;

endpackage : dcache_pkg

// ==== logic/stb_pkg.sv ====
//########################################
// Store buffer definitions
// Entry layout, default depth and the
// cache controller state encoding
//########################################

package stb_pkg;

    // Default number of entries, power of two
    localparam int unsigned STB_DEPTH = 8;

    // One buffered store as it leaves the load-store unit
    typedef struct packed {
        dcache_pkg::addr_t addr;
        dcache_pkg::data_t data;
        dcache_pkg::mask_t mask;   // Byte enables
    } stb_entry_t;

    // Drain FSM
    typedef enum logic {
        IDLE           = 1'b0,
        SB_CACHE_WRITE = 1'b1   // Buffer owns the cache write port
    } stb_state_t;

endpackage : stb_pkg

// ==== logic/stb_ifs.sv ====
//########################################
// Store buffer internal buses
// Pointer bus and cache write port
//########################################

`timescale 1ns/10ps

interface stb_ptr_if #(
    parameter int unsigned DEPTH = stb_pkg::STB_DEPTH
);
    localparam int unsigned PTR_W = $clog2(DEPTH);

    logic             push;     // Store accepted this cycle
    logic             pop;      // Head entry written to cache
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             empty;
    logic             full;

    modport counter    (output push, wr_ptr, rd_ptr, empty, full, input pop);
    modport datapath   (input push, wr_ptr, rd_ptr);
    modport controller (input empty, output pop);
endinterface : stb_ptr_if

interface dcache_wr_if;
    import dcache_pkg::*;

    logic  req;
    logic  owned;   // Store buffer holds the write port
    logic  ack;     // One-cycle pulse from the cache
    addr_t addr;
    data_t data;
    mask_t mask;

    modport controller (output req, owned, input ack);
    modport datapath   (output addr, data, mask, input req);
    modport top        (input req, owned, addr, data, mask, output ack);
endinterface : dcache_wr_if

// ==== logic/stb_ptr_counter.sv ====
//########################################
// Store buffer pointer counter
// Write/read pointers, occupancy and the
// registered empty and full flags
//########################################

`timescale 1ns/10ps

module stb_ptr_counter #(
    parameter int unsigned DEPTH = stb_pkg::STB_DEPTH
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          store_valid,
    stb_ptr_if.counter    ptr
);
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;

    // Only place a store gets accepted
    assign ptr.push = store_valid && !ptr.full;

    always_comb begin
        case ({ptr.push, ptr.pop})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;    // Idle or push and pop together
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr.wr_ptr <= '0;
            ptr.rd_ptr <= '0;
            count      <= '0;
            ptr.empty  <= 1'b1;
            ptr.full   <= 1'b0;
        end else begin
            if (ptr.push) begin
                ptr.wr_ptr <= ptr.wr_ptr + 1'b1;   // Wraps at DEPTH
            end
            if (ptr.pop) begin
                ptr.rd_ptr <= ptr.rd_ptr + 1'b1;
            end
            count     <= count_nxt;
            ptr.empty <= (count_nxt == '0);
            ptr.full  <= (count_nxt == CNT_W'(DEPTH));
        end
    end

    // Controller must never drain an empty buffer
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) ptr.pop |-> !ptr.empty
    );

    a_count_bounded: assert property (
        @(posedge clk) disable iff (!rst_n) count <= CNT_W'(DEPTH)
    );

endmodule : stb_ptr_counter

// ==== logic/stb_datapath.sv ====
//########################################
// Store buffer datapath
// Entry array written at the write
// pointer, head entry onto the cache port
//########################################

`timescale 1ns/10ps

module stb_datapath #(
    parameter int unsigned DEPTH = stb_pkg::STB_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  stb_pkg::stb_entry_t store_in,
    stb_ptr_if.datapath         ptr,
    dcache_wr_if.datapath       cache
);
    import stb_pkg::*;

    stb_entry_t entries [DEPTH];
    stb_entry_t head;

    // Payload only, no reset needed
    always_ff @(posedge clk) begin
        if (ptr.push) begin
            entries[ptr.wr_ptr] <= store_in;
        end
    end

    // Oldest store, selected straight from the read pointer
    assign head = entries[ptr.rd_ptr];

    assign cache.addr = head.addr;
    assign cache.data = head.data;
    assign cache.mask = head.mask;

    // A pending request must see the same store until it is acknowledged
    a_payload_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cache.req ##1 cache.req) |-> $stable({cache.addr, cache.data, cache.mask})
    );

endmodule : stb_datapath

// ==== logic/stb_cache_controller.sv ====
//########################################
// Store buffer cache controller
// Drains entries to the data cache with a
// req/ack handshake, oldest first
//########################################

`timescale 1ns/10ps

module stb_cache_controller (
    input  logic             clk,
    input  logic             rst_n,
    stb_ptr_if.controller    ptr,
    dcache_wr_if.controller  cache
);
    import stb_pkg::*;

    stb_state_t state;
    stb_state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        cache.req   = 1'b0;
        cache.owned = 1'b0;
        ptr.pop     = 1'b0;

        case (state)
            IDLE: begin
                if (!ptr.empty) begin
                    cache.req   = 1'b1;   // First request of a burst
                    cache.owned = 1'b1;
                    next_state  = SB_CACHE_WRITE;
                end
            end

            SB_CACHE_WRITE: begin
                if (cache.ack) begin
                    // Head written so req drops and the entry retires
                    cache.owned = 1'b1;
                    ptr.pop     = 1'b1;
                end else if (!ptr.empty) begin
                    cache.req   = 1'b1;
                    cache.owned = 1'b1;
                end else begin
                    next_state  = IDLE;   // Drained and the port is released
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // An entry retires only on the ack that answers a request
    a_pop_on_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        ptr.pop |-> cache.ack && $past(cache.req)
    );

    // No request is withdrawn before the cache answers
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        cache.req |=> cache.req || cache.ack
    );

endmodule : stb_cache_controller

// ==== logic/store_buffer.sv ====
//########################################
// Store buffer top level
// Load-store unit stores in, ordered
// cache writes out
//########################################

`timescale 1ns/10ps

module store_buffer #(
    parameter int unsigned DEPTH = stb_pkg::STB_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,

    // Load-store unit side
    input  logic              store_valid,
    input  dcache_pkg::addr_t store_addr,
    input  dcache_pkg::data_t store_data,
    input  dcache_pkg::mask_t store_mask,
    output logic              stb_full,

    // Data cache side
    output logic              dcache_req,
    output dcache_pkg::addr_t dcache_addr,
    output dcache_pkg::data_t dcache_data,
    output dcache_pkg::mask_t dcache_mask,
    output logic              dcache_owned,
    input  logic              dcache_ack
);
    import stb_pkg::*;

    stb_entry_t store_entry;

    stb_ptr_if #(.DEPTH(DEPTH)) ptr_bus ();
    dcache_wr_if                cache_bus ();

    assign store_entry = '{addr: store_addr, data: store_data, mask: store_mask};

    stb_ptr_counter #(.DEPTH(DEPTH)) u_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_valid (store_valid),
        .ptr         (ptr_bus.counter)
    );

    stb_datapath #(.DEPTH(DEPTH)) u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .store_in (store_entry),
        .ptr      (ptr_bus.datapath),
        .cache    (cache_bus.datapath)
    );

    stb_cache_controller u_controller (
        .clk   (clk),
        .rst_n (rst_n),
        .ptr   (ptr_bus.controller),
        .cache (cache_bus.controller)
    );

    assign stb_full      = ptr_bus.full;   // Holds off the store source
    assign dcache_req    = cache_bus.req;
    assign dcache_addr   = cache_bus.addr;
    assign dcache_data   = cache_bus.data;
    assign dcache_mask   = cache_bus.mask;
    assign dcache_owned  = cache_bus.owned;
    assign cache_bus.ack = dcache_ack;

endmodule : store_buffer

// ==== verification/store_buffer_tb.sv ====
//########################################
// Store buffer testbench
// File driven stores, cache model with
// ack delays, in-order scoreboard
//########################################

`timescale 1ns/10ps

module store_buffer_tb;
    import dcache_pkg::*;
    import stb_pkg::*;

    localparam int unsigned DEPTH      = 8;
    localparam int          WAIT_LIMIT = 200;   // Cycles allowed for any single wait

    logic  clk;
    logic  rst_n;
    logic  store_valid;
    addr_t store_addr;
    data_t store_data;
    mask_t store_mask;
    logic  stb_full;
    logic  dcache_req;
    addr_t dcache_addr;
    data_t dcache_data;
    mask_t dcache_mask;
    logic  dcache_owned;
    logic  dcache_ack;

    stb_entry_t exp_q[$];      // Accepted but not yet acknowledged
    int         delay_q[$];    // Ack delay of each queued store
    stb_entry_t seen_store;
    int         cur_delay;
    int         wait_cnt;
    int         accepted_cnt;
    int         acked_cnt;
    bit         saw_full;
    bit         saw_held;
    logic       req_s;         // dcache_req at the last falling edge
    addr_t      held_addr;
    data_t      held_data;
    mask_t      held_mask;

    store_buffer #(.DEPTH(DEPTH)) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .store_mask   (store_mask),
        .stb_full     (stb_full),
        .dcache_req   (dcache_req),
        .dcache_addr  (dcache_addr),
        .dcache_data  (dcache_data),
        .dcache_mask  (dcache_mask),
        .dcache_owned (dcache_owned),
        .dcache_ack   (dcache_ack)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        stop_with_failure();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Store goes in at the next rising edge once stb_full is seen low
    task automatic wait_accept();
        int waited;
        waited = 0;
        @(negedge clk);
        while (stb_full) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_error("held store was never accepted while stb_full stayed high");
            end
            @(negedge clk);
        end
    endtask

    // Cache model answers each request after the delay of the head store
    always @(posedge clk) begin
        #0.5;
        if (!rst_n) begin
            dcache_ack = 1'b0;
            wait_cnt   = 0;
        end else if (req_s && delay_q.size() != 0 && wait_cnt >= delay_q[0]) begin
            dcache_ack = 1'b1;
            wait_cnt   = 0;
        end else begin
            dcache_ack = 1'b0;
            if (req_s) begin
                wait_cnt++;
            end
        end
    end

    // Scoreboard sampled mid-cycle where all outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            check_value(stb_full, exp_q.size() == DEPTH, "stb_full against buffered stores");
            if (dcache_req) begin
                check_value(exp_q.size() != 0, 1, "dcache_req with nothing buffered");
                check_value(dcache_owned, 1'b1, "dcache_owned low during dcache_req");
                check_value(dcache_addr, exp_q[0].addr, "dcache_addr against oldest store");
                check_value(dcache_data, exp_q[0].data, "dcache_data against oldest store");
                check_value(dcache_mask, exp_q[0].mask, "dcache_mask against oldest store");
                if (req_s) begin   // Request still pending
                    check_value(dcache_addr, held_addr, "dcache_addr changed under req");
                    check_value(dcache_data, held_data, "dcache_data changed under req");
                    check_value(dcache_mask, held_mask, "dcache_mask changed under req");
                end
            end
            if (dcache_ack) begin
                check_value(dcache_req, 1'b0, "dcache_req high during dcache_ack");
                check_value(dcache_owned, 1'b1, "dcache_owned low during dcache_ack");
                check_value(exp_q.size() != 0, 1, "dcache_ack with nothing buffered");
                void'(exp_q.pop_front());
                void'(delay_q.pop_front());
                acked_cnt++;
            end
            if (store_valid && !stb_full) begin
                seen_store = '{addr: store_addr, data: store_data, mask: store_mask};
                exp_q.push_back(seen_store);
                delay_q.push_back(cur_delay);
                accepted_cnt++;
            end
            saw_held  = saw_held || (store_valid && stb_full);
            saw_full  = saw_full || stb_full;
            req_s     = dcache_req;
            held_addr = dcache_addr;
            held_data = dcache_data;
            held_mask = dcache_mask;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          waited;
        int          dly;
        string       line;
        logic [31:0] rng;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  m;

        clk          = 1'b0;
        rst_n        = 1'b0;
        store_valid  = 1'b0;
        store_addr   = '0;
        store_data   = '0;
        store_mask   = '0;
        dcache_ack   = 1'b0;
        cur_delay    = 0;
        wait_cnt     = 0;
        accepted_cnt = 0;
        acked_cnt    = 0;
        saw_full     = 1'b0;
        saw_held     = 1'b0;
        req_s        = 1'b0;
        rng          = 32'd30098;

        repeat (10) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        @(negedge clk);
        check_value(dcache_req, 1'b0, "dcache_req after reset");
        check_value(dcache_owned, 1'b0, "dcache_owned after reset");
        check_value(stb_full, 1'b0, "stb_full after reset");

        fd = $fopen("verification/stb_stimulus.txt", "r");
        if (fd == 0) begin
            report_error("could not open the stimulus file");
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;   // Comment or blank
            end
            n = $sscanf(line, "%h %h %h %d", a, d, m, dly);
            if (n != 4) begin
                report_error("stimulus line does not hold four fields");
            end
            if (dly == 99) begin
                rng = xorshift32(rng);
                dly = rng % 4;
            end
            @(posedge clk);
            #0.5;
            store_valid = 1'b1;
            store_addr  = a;
            store_data  = d;
            store_mask  = m;
            cur_delay   = dly;
            wait_accept();
        end
        $fclose(fd);
        @(posedge clk);
        #0.5;
        store_valid = 1'b0;

        // Port is released once the buffer has drained
        waited = 0;
        @(negedge clk);
        while (dcache_owned) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_error("dcache_owned did not fall after the stimulus ended");
            end
            @(negedge clk);
        end

        repeat (5) begin
            @(negedge clk);
            check_value(dcache_req, 1'b0, "dcache_req after drain");
        end

        @(posedge clk);
        check_value(acked_cnt, accepted_cnt, "acknowledged writes against accepted stores");
        check_value(saw_full, 1'b1, "stb_full seen during the stall");
        check_value(saw_held, 1'b1, "store held off by stb_full");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : store_buffer_tb

// ==== verification/stb_stimulus.txt ====
# addr(hex) data(hex) mask(hex) ack_delay(decimal cycles, 99 = random 0..3)
# One store per line, written to the cache in this order
00001000 a5a50001 f 99
00001004 a5a50002 3 99
00001008 a5a50003 c 0
0000100c a5a50004 1 99
00002000 5a5a0005 f 40
00002004 5a5a0006 2 99
00002008 5a5a0007 4 99
0000200c 5a5a0008 8 1
00002010 5a5a0009 f 99
00002014 5a5a000a 6 99
00002018 5a5a000b 9 0
0000201c 5a5a000c f 99
00003000 c3c3000d 3 99
00003004 c3c3000e c 2
00003008 c3c3000f f 99
0000300c c3c30010 1 25
00003010 c3c30011 f 99
00003014 c3c30012 5 99
00003018 c3c30013 a 0
0000301c c3c30014 f 99
00004000 3c3c0015 7 99
00004004 3c3c0016 e 3
00004008 3c3c0017 f 99
0000400c 3c3c0018 b 0
00004010 3c3c0019 d 99
00004014 3c3c001a f 99

// ==== store_buffer.f ====
logic/dcache_pkg.sv
logic/stb_pkg.sv
logic/stb_ifs.sv
logic/stb_ptr_counter.sv
logic/stb_datapath.sv
logic/stb_cache_controller.sv
logic/store_buffer.sv
verification/store_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: store_buffer

sources:
  # Packages first, the store buffer types use the cache port types
  - files:
      - logic/dcache_pkg.sv
      - logic/stb_pkg.sv
      - logic/stb_ifs.sv
      - logic/stb_ptr_counter.sv
      - logic/stb_datapath.sv
      - logic/stb_cache_controller.sv
      - logic/store_buffer.sv

  # Testbench, top module store_buffer_tb
  - target: test
    files:
      - verification/store_buffer_tb.sv

export_include_dirs: []

dependencies: {}
